//--- src/croc_lite_bus_pkg.sv
package croc_lite_bus_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ----------------------------------------------------------
  // Response sources behind the decoder
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    TgtBank0,
    TgtBank1,
    TgtSocCtrl,
    TgtGpio,
    TgtError  // Default for unmapped addresses
  } obi_target_e;

endpackage

//--- src/croc_lite_map_pkg.sv
package croc_lite_map_pkg;

  // ----------------------------------------------------------
  // Memory map
  // ----------------------------------------------------------
  localparam croc_lite_bus_pkg::addr_t SramBaseAddr = 32'h1000_0000;
  localparam int unsigned SramBankNumWords  = 256;
  localparam int unsigned NumSramBanks      = 2;
  localparam int unsigned SramBankAddrWidth = $clog2(SramBankNumWords);

  // Peripherals each own a 4 KiB window
  localparam int unsigned PeriphOffsetWidth = 12;
  localparam croc_lite_bus_pkg::addr_t SocCtrlBaseAddr  = 32'h0300_0000;
  localparam croc_lite_bus_pkg::addr_t GpioBaseAddr     = 32'h0300_5000;
  localparam croc_lite_bus_pkg::addr_t PeriphWindowMask = (32'h1 << PeriphOffsetWidth) - 32'h1;

  // Register offsets inside a window
  typedef enum logic [PeriphOffsetWidth-1:0] {
    RegBootAddr = 12'h000,
    RegFetchEn  = 12'h004
  } soc_ctrl_reg_e;

  typedef enum logic [PeriphOffsetWidth-1:0] {
    RegGpioDir = 12'h000,
    RegGpioOut = 12'h004,
    RegGpioIn  = 12'h008
  } gpio_reg_e;

  localparam croc_lite_bus_pkg::addr_t BootAddrDefault = SramBaseAddr;
  localparam croc_lite_bus_pkg::data_t ErrRspData      = 32'hbadc_ab1e;
  localparam int unsigned GpioCount = 16;

endpackage

//--- src/obi_bus_if.sv
`timescale 1ns/1ps

interface obi_bus_if;

  // Request side, grant is implicitly high
  logic                     req;
  logic                     we;
  croc_lite_bus_pkg::be_t   be;
  croc_lite_bus_pkg::addr_t addr;
  croc_lite_bus_pkg::data_t wdata;

  // Response side, one cycle after req
  logic                     rvalid;
  croc_lite_bus_pkg::data_t rdata;
  logic                     err;

  modport mgr (output req, we, be, addr, wdata,
               input  rvalid, rdata, err);

  modport sbr (input  req, we, be, addr, wdata,
               output rvalid, rdata, err);

endinterface

//--- src/sram_bank.sv
`timescale 1ns/1ps

module sram_bank (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);

  croc_lite_bus_pkg::data_t mem [croc_lite_map_pkg::SramBankNumWords];
  croc_lite_bus_pkg::data_t rdata_q;
  logic [croc_lite_map_pkg::SramBankAddrWidth-1:0] word_idx;
  logic rvalid_q;

  // Byte address to word index
  assign word_idx = bus.addr[croc_lite_map_pkg::SramBankAddrWidth+1:2];

  // Array and read data, no reset
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < croc_lite_bus_pkg::BeWidth; b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

//--- src/soc_ctrl_regs.sv
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  obi_bus_if.sbr                   bus,
  input  logic                     fetch_en_i,
  output logic                     fetch_enable_o,
  output croc_lite_bus_pkg::addr_t boot_addr_o
);

  croc_lite_map_pkg::soc_ctrl_reg_e reg_sel;
  croc_lite_bus_pkg::addr_t boot_addr_q;
  croc_lite_bus_pkg::data_t rd_data;
  croc_lite_bus_pkg::data_t rdata_q;
  logic fetch_en_q;
  logic rvalid_q;

  assign reg_sel = croc_lite_map_pkg::soc_ctrl_reg_e'(
      bus.addr[croc_lite_map_pkg::PeriphOffsetWidth-1:0]);

  // Read mux, unmapped offsets read zero
  always_comb begin
    case (reg_sel)
      croc_lite_map_pkg::RegBootAddr: rd_data = boot_addr_q;
      croc_lite_map_pkg::RegFetchEn:  rd_data = {31'b0, fetch_en_q};
      default:                        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= croc_lite_map_pkg::BootAddrDefault;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (bus.req && bus.we) begin
        case (reg_sel)
          croc_lite_map_pkg::RegBootAddr: boot_addr_q <= bus.wdata;
          croc_lite_map_pkg::RegFetchEn:  fetch_en_q  <= bus.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_data;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  // External pin can also start the fetch
  assign fetch_enable_o = fetch_en_q | fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

//--- src/gpio_ctrl.sv
`timescale 1ns/1ps

module gpio_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  obi_bus_if.sbr                                bus,
  input  logic [croc_lite_map_pkg::GpioCount-1:0] gpio_i,
  output logic [croc_lite_map_pkg::GpioCount-1:0] gpio_o,
  output logic [croc_lite_map_pkg::GpioCount-1:0] gpio_out_en_o
);

  croc_lite_map_pkg::gpio_reg_e reg_sel;
  croc_lite_bus_pkg::data_t rd_data;
  croc_lite_bus_pkg::data_t rdata_q;
  logic [croc_lite_map_pkg::GpioCount-1:0] dir_q;
  logic [croc_lite_map_pkg::GpioCount-1:0] out_q;
  logic [croc_lite_map_pkg::GpioCount-1:0] in_meta_q;
  logic [croc_lite_map_pkg::GpioCount-1:0] in_sync_q;
  logic rvalid_q;

  assign reg_sel = croc_lite_map_pkg::gpio_reg_e'(
      bus.addr[croc_lite_map_pkg::PeriphOffsetWidth-1:0]);

  // ----------------------------------------------------------
  // Input synchronizer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  // ----------------------------------------------------------
  // Register access
  // ----------------------------------------------------------
  always_comb begin
    case (reg_sel)
      croc_lite_map_pkg::RegGpioDir: rd_data = croc_lite_bus_pkg::data_t'(dir_q);
      croc_lite_map_pkg::RegGpioOut: rd_data = croc_lite_bus_pkg::data_t'(out_q);
      croc_lite_map_pkg::RegGpioIn:  rd_data = croc_lite_bus_pkg::data_t'(in_sync_q);
      default:                       rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      // RegGpioIn falls to default, so writes to it are dropped
      if (bus.req && bus.we) begin
        case (reg_sel)
          croc_lite_map_pkg::RegGpioDir: dir_q <= bus.wdata[croc_lite_map_pkg::GpioCount-1:0];
          croc_lite_map_pkg::RegGpioOut: out_q <= bus.wdata[croc_lite_map_pkg::GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_data;
    end
  end

  assign bus.rvalid    = rvalid_q;
  assign bus.rdata     = rdata_q;
  assign bus.err       = 1'b0;
  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;

endmodule

//--- src/obi_addr_decode.sv
`timescale 1ns/1ps

module obi_addr_decode (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     obi_req_i,
  input  logic                     obi_we_i,
  input  croc_lite_bus_pkg::be_t   obi_be_i,
  input  croc_lite_bus_pkg::addr_t obi_addr_i,
  input  croc_lite_bus_pkg::data_t obi_wdata_i,
  output logic                     obi_rvalid_o,
  output croc_lite_bus_pkg::data_t obi_rdata_o,
  output logic                     obi_err_o,
  obi_bus_if.mgr                   bank0_bus,
  obi_bus_if.mgr                   bank1_bus,
  obi_bus_if.mgr                   soc_ctrl_bus,
  obi_bus_if.mgr                   gpio_bus
);

  localparam croc_lite_bus_pkg::addr_t SramEndAddr = croc_lite_map_pkg::SramBaseAddr +
      croc_lite_bus_pkg::addr_t'(croc_lite_map_pkg::NumSramBanks *
      croc_lite_map_pkg::SramBankNumWords * croc_lite_bus_pkg::BeWidth);
  // Lowest address bit above one bank
  localparam int unsigned BankSelBit =
      croc_lite_map_pkg::SramBankAddrWidth + $clog2(croc_lite_bus_pkg::BeWidth);

  croc_lite_bus_pkg::obi_target_e tgt_sel;
  croc_lite_bus_pkg::obi_target_e rsp_tgt_q;
  logic sram_hit;
  logic soc_ctrl_hit;
  logic gpio_hit;
  logic err_valid_q;
  logic err_rd_q;

  // ----------------------------------------------------------
  // Address decoding
  // ----------------------------------------------------------
  assign sram_hit = (obi_addr_i >= croc_lite_map_pkg::SramBaseAddr) &&
                    (obi_addr_i < SramEndAddr);
  assign soc_ctrl_hit = (obi_addr_i & ~croc_lite_map_pkg::PeriphWindowMask) ==
                        croc_lite_map_pkg::SocCtrlBaseAddr;
  assign gpio_hit = (obi_addr_i & ~croc_lite_map_pkg::PeriphWindowMask) ==
                    croc_lite_map_pkg::GpioBaseAddr;

  always_comb begin
    tgt_sel = croc_lite_bus_pkg::TgtError;
    if (sram_hit) begin
      if (obi_addr_i[BankSelBit]) begin
        tgt_sel = croc_lite_bus_pkg::TgtBank1;
      end else begin
        tgt_sel = croc_lite_bus_pkg::TgtBank0;
      end
    end else if (soc_ctrl_hit) begin
      tgt_sel = croc_lite_bus_pkg::TgtSocCtrl;
    end else if (gpio_hit) begin
      tgt_sel = croc_lite_bus_pkg::TgtGpio;
    end
  end

  // Request fanout, only the selected target sees req
  assign bank0_bus.req      = obi_req_i && (tgt_sel == croc_lite_bus_pkg::TgtBank0);
  assign bank0_bus.we       = obi_we_i;
  assign bank0_bus.be       = obi_be_i;
  assign bank0_bus.addr     = obi_addr_i;
  assign bank0_bus.wdata    = obi_wdata_i;
  assign bank1_bus.req      = obi_req_i && (tgt_sel == croc_lite_bus_pkg::TgtBank1);
  assign bank1_bus.we       = obi_we_i;
  assign bank1_bus.be       = obi_be_i;
  assign bank1_bus.addr     = obi_addr_i;
  assign bank1_bus.wdata    = obi_wdata_i;
  assign soc_ctrl_bus.req   = obi_req_i && (tgt_sel == croc_lite_bus_pkg::TgtSocCtrl);
  assign soc_ctrl_bus.we    = obi_we_i;
  assign soc_ctrl_bus.be    = obi_be_i;
  assign soc_ctrl_bus.addr  = obi_addr_i;
  assign soc_ctrl_bus.wdata = obi_wdata_i;
  assign gpio_bus.req       = obi_req_i && (tgt_sel == croc_lite_bus_pkg::TgtGpio);
  assign gpio_bus.we        = obi_we_i;
  assign gpio_bus.be        = obi_be_i;
  assign gpio_bus.addr      = obi_addr_i;
  assign gpio_bus.wdata     = obi_wdata_i;

  // ----------------------------------------------------------
  // In-flight target and error subordinate
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_tgt_q   <= croc_lite_bus_pkg::TgtError;
      err_valid_q <= 1'b0;
      err_rd_q    <= 1'b0;
    end else begin
      if (obi_req_i) begin
        rsp_tgt_q <= tgt_sel;
      end
      err_valid_q <= obi_req_i && (tgt_sel == croc_lite_bus_pkg::TgtError);
      err_rd_q    <= obi_req_i && !obi_we_i && (tgt_sel == croc_lite_bus_pkg::TgtError);
    end
  end

  // Response mux steered by last cycle's target
  always_comb begin
    case (rsp_tgt_q)
      croc_lite_bus_pkg::TgtBank0: begin
        obi_rvalid_o = bank0_bus.rvalid;
        obi_rdata_o  = bank0_bus.rdata;
        obi_err_o    = bank0_bus.err;
      end
      croc_lite_bus_pkg::TgtBank1: begin
        obi_rvalid_o = bank1_bus.rvalid;
        obi_rdata_o  = bank1_bus.rdata;
        obi_err_o    = bank1_bus.err;
      end
      croc_lite_bus_pkg::TgtSocCtrl: begin
        obi_rvalid_o = soc_ctrl_bus.rvalid;
        obi_rdata_o  = soc_ctrl_bus.rdata;
        obi_err_o    = soc_ctrl_bus.err;
      end
      croc_lite_bus_pkg::TgtGpio: begin
        obi_rvalid_o = gpio_bus.rvalid;
        obi_rdata_o  = gpio_bus.rdata;
        obi_err_o    = gpio_bus.err;
      end
      default: begin
        obi_rvalid_o = err_valid_q;
        obi_rdata_o  = err_rd_q ? croc_lite_map_pkg::ErrRspData : '0;
        obi_err_o    = err_valid_q;
      end
    endcase
  end

endmodule

//--- src/croc_lite_top.sv
`timescale 1ns/1ps

module croc_lite_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,

  input  logic                                    obi_req_i,
  input  logic                                    obi_we_i,
  input  croc_lite_bus_pkg::be_t                  obi_be_i,
  input  croc_lite_bus_pkg::addr_t                obi_addr_i,
  input  croc_lite_bus_pkg::data_t                obi_wdata_i,
  output logic                                    obi_rvalid_o,
  output logic                                    obi_err_o,
  output croc_lite_bus_pkg::data_t                obi_rdata_o,

  input  logic [croc_lite_map_pkg::GpioCount-1:0] gpio_i,
  output logic [croc_lite_map_pkg::GpioCount-1:0] gpio_o,
  output logic [croc_lite_map_pkg::GpioCount-1:0] gpio_out_en_o,

  input  logic                                    fetch_en_i,
  output logic                                    fetch_enable_o,
  output croc_lite_bus_pkg::addr_t                boot_addr_o
);

  // ----------------------------------------------------------
  // Decoder to subordinate buses
  // ----------------------------------------------------------
  obi_bus_if bank_bus [croc_lite_map_pkg::NumSramBanks] ();
  obi_bus_if soc_ctrl_bus ();
  obi_bus_if gpio_bus ();

  obi_addr_decode i_addr_decode (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_we_i,
    .obi_be_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_rvalid_o,
    .obi_rdata_o,
    .obi_err_o,
    .bank0_bus    ( bank_bus[0]  ),
    .bank1_bus    ( bank_bus[1]  ),
    .soc_ctrl_bus ( soc_ctrl_bus ),
    .gpio_bus     ( gpio_bus     )
  );

  // ----------------------------------------------------------
  // Subordinates
  // ----------------------------------------------------------
  for (genvar i = 0; i < croc_lite_map_pkg::NumSramBanks; i++) begin : gen_sram_bank
    sram_bank i_sram_bank (
      .clk_i,
      .rst_n_i,
      .bus ( bank_bus[i] )
    );
  end

  soc_ctrl_regs i_soc_ctrl (
    .clk_i,
    .rst_n_i,
    .bus ( soc_ctrl_bus ),
    .fetch_en_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  gpio_ctrl i_gpio (
    .clk_i,
    .rst_n_i,
    .bus ( gpio_bus ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o
  );

endmodule

//--- sim/croc_lite_asserts.sv
`timescale 1ns/1ps

module croc_lite_asserts (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic                                    obi_req_i,
  input logic                                    obi_we_i,
  input logic                                    obi_rvalid_o,
  input logic                                    obi_err_o,
  input croc_lite_bus_pkg::data_t                obi_rdata_o,
  input logic [croc_lite_map_pkg::GpioCount-1:0] gpio_o,
  input logic [croc_lite_map_pkg::GpioCount-1:0] gpio_out_en_o,
  input logic                                    fetch_enable_o,
  input croc_lite_bus_pkg::addr_t                boot_addr_o
);

  // ----------------------------------------------------------
  // OBI response protocol
  // ----------------------------------------------------------
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      obi_rvalid_o == $past(obi_req_i))
    else $error("obi_rvalid_o does not follow obi_req_i by one cycle");

  err_read_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (obi_rvalid_o && obi_err_o && !$past(obi_we_i)) |->
      (obi_rdata_o == croc_lite_map_pkg::ErrRspData))
    else $error("error response to a read carries wrong obi_rdata_o");

  // No unknown values once out of reset
  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$isunknown({obi_rvalid_o, obi_err_o, gpio_o, gpio_out_en_o,
                   fetch_enable_o, boot_addr_o}))
    else $error("unknown value on a top-level output");

  rdata_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      obi_rvalid_o |-> !$isunknown(obi_rdata_o))
    else $error("unknown obi_rdata_o with obi_rvalid_o high");

endmodule

bind croc_lite_top croc_lite_asserts u_asserts (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .obi_req_i      ( obi_req_i      ),
  .obi_we_i       ( obi_we_i       ),
  .obi_rvalid_o   ( obi_rvalid_o   ),
  .obi_err_o      ( obi_err_o      ),
  .obi_rdata_o    ( obi_rdata_o    ),
  .gpio_o         ( gpio_o         ),
  .gpio_out_en_o  ( gpio_out_en_o  ),
  .fetch_enable_o ( fetch_enable_o ),
  .boot_addr_o    ( boot_addr_o    )
);

//--- sim/tb_croc_lite.sv
`timescale 1ns/1ps

module tb_croc_lite;

  localparam int unsigned SramOps    = 400;
  localparam int unsigned SocOps     = 100;
  localparam int unsigned GpioRounds = 30;
  localparam int unsigned ErrOps     = 100;
  localparam int unsigned SramWords  =
      croc_lite_map_pkg::NumSramBanks * croc_lite_map_pkg::SramBankNumWords;
  // Reset, fill, random traffic and drain cycles, with a threefold margin
  localparam int unsigned EstCycles  =
      5 + 8 + SramWords + SramOps + 2 * SocOps + 11 * GpioRounds + ErrOps + 20;
  localparam int unsigned MaxCycles  = 3 * EstCycles;

  logic                                    clk_i;
  logic                                    rst_n_i;
  logic                                    obi_req_i;
  logic                                    obi_we_i;
  croc_lite_bus_pkg::be_t                  obi_be_i;
  croc_lite_bus_pkg::addr_t                obi_addr_i;
  croc_lite_bus_pkg::data_t                obi_wdata_i;
  logic                                    obi_rvalid_o;
  logic                                    obi_err_o;
  croc_lite_bus_pkg::data_t                obi_rdata_o;
  logic [croc_lite_map_pkg::GpioCount-1:0] gpio_i;
  logic [croc_lite_map_pkg::GpioCount-1:0] gpio_o;
  logic [croc_lite_map_pkg::GpioCount-1:0] gpio_out_en_o;
  logic                                    fetch_en_i;
  logic                                    fetch_enable_o;
  croc_lite_bus_pkg::addr_t                boot_addr_o;

  // ----------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------
  logic [31:0] mdl_sram [SramWords];
  logic [31:0] mdl_boot_addr;
  logic        mdl_fetch_en;
  logic [15:0] mdl_gpio_dir;
  logic [15:0] mdl_gpio_out;
  logic [15:0] mdl_gpio_in;

  // Response expected for the request now in flight
  logic        exp_valid;
  logic        exp_err;
  logic [31:0] exp_rdata;

  // Pin values applied with the next bus cycle
  logic        fetch_en_nxt;
  logic [15:0] gpio_nxt;

  logic [31:0] lfsr_q;
  int unsigned cycle_cnt = 0;
  int unsigned check_cnt = 0;
  int unsigned err_cnt   = 0;
  int unsigned test_base = 0;

  croc_lite_top u_croc_lite_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Random numbers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // ----------------------------------------------------------
  // Model of the address map
  // ----------------------------------------------------------
  function automatic croc_lite_bus_pkg::obi_target_e target_of(input logic [31:0] addr);
    if (addr - croc_lite_map_pkg::SramBaseAddr < 32'h0000_0800) begin
      return addr[10] ? croc_lite_bus_pkg::TgtBank1 : croc_lite_bus_pkg::TgtBank0;
    end
    if ((addr >> 12) == (croc_lite_map_pkg::SocCtrlBaseAddr >> 12)) begin
      return croc_lite_bus_pkg::TgtSocCtrl;
    end
    if ((addr >> 12) == (croc_lite_map_pkg::GpioBaseAddr >> 12)) begin
      return croc_lite_bus_pkg::TgtGpio;
    end
    return croc_lite_bus_pkg::TgtError;
  endfunction

  // Read data is the value before the write of the same request
  task automatic model_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic err,
                              output logic [31:0] rdata);
    croc_lite_bus_pkg::obi_target_e tgt;
    logic [8:0]  idx;
    logic [11:0] offs;
    logic [31:0] old;
    tgt  = target_of(addr);
    idx  = addr[10:2];
    offs = addr[11:0];
    old  = '0;
    err  = 1'b0;
    case (tgt)
      croc_lite_bus_pkg::TgtBank0, croc_lite_bus_pkg::TgtBank1: begin
        old = mdl_sram[idx];
        for (int b = 0; b < 4; b++) begin
          if (we && be[b]) begin
            mdl_sram[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
      croc_lite_bus_pkg::TgtSocCtrl: begin
        if (offs == croc_lite_map_pkg::RegBootAddr) begin
          old = mdl_boot_addr;
          mdl_boot_addr = we ? wdata : mdl_boot_addr;
        end else if (offs == croc_lite_map_pkg::RegFetchEn) begin
          old = {31'b0, mdl_fetch_en};
          mdl_fetch_en = we ? wdata[0] : mdl_fetch_en;
        end
      end
      croc_lite_bus_pkg::TgtGpio: begin
        if (offs == croc_lite_map_pkg::RegGpioDir) begin
          old = {16'b0, mdl_gpio_dir};
          mdl_gpio_dir = we ? wdata[15:0] : mdl_gpio_dir;
        end else if (offs == croc_lite_map_pkg::RegGpioOut) begin
          old = {16'b0, mdl_gpio_out};
          mdl_gpio_out = we ? wdata[15:0] : mdl_gpio_out;
        end else if (offs == croc_lite_map_pkg::RegGpioIn) begin
          old = {16'b0, mdl_gpio_in};
        end
      end
      default: begin
        err = 1'b1;
        old = croc_lite_map_pkg::ErrRspData;
      end
    endcase
    rdata = we ? 32'h0 : old;
  endtask

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_response();
    check_eq("obi_rvalid_o", 32'(obi_rvalid_o), 32'(exp_valid));
    if (exp_valid) begin
      check_eq("obi_err_o", 32'(obi_err_o), 32'(exp_err));
      check_eq("obi_rdata_o", obi_rdata_o, exp_rdata);
    end
  endtask

  task automatic check_pins();
    check_eq("boot_addr_o", boot_addr_o, mdl_boot_addr);
    check_eq("fetch_enable_o", 32'(fetch_enable_o), 32'(mdl_fetch_en | fetch_en_nxt));
    check_eq("gpio_o", 32'(gpio_o), 32'(mdl_gpio_out));
    check_eq("gpio_out_en_o", 32'(gpio_out_en_o), 32'(mdl_gpio_dir));
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, err_cnt - test_base);
    test_base = err_cnt;
  endtask

  // ----------------------------------------------------------
  // Bus driver, one request per clock
  // ----------------------------------------------------------
  task automatic bus_cycle(input logic req, input logic we, input logic [3:0] be,
                           input logic [31:0] addr, input logic [31:0] wdata);
    logic        nxt_err;
    logic [31:0] nxt_rdata;
    @(posedge clk_i);
    #1;
    obi_req_i   = req;
    obi_we_i    = we;
    obi_be_i    = be;
    obi_addr_i  = addr;
    obi_wdata_i = wdata;
    fetch_en_i  = fetch_en_nxt;
    gpio_i      = gpio_nxt;
    nxt_err     = 1'b0;
    nxt_rdata   = '0;
    if (req) begin
      model_access(we, be, addr, wdata, nxt_err, nxt_rdata);
    end
    // Response of the previous cycle's request is stable here
    @(negedge clk_i);
    check_response();
    exp_valid = req;
    exp_err   = nxt_err;
    exp_rdata = nxt_rdata;
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, 4'h0, obi_addr_i, obi_wdata_i);
  endtask

  task automatic read_word(input logic [31:0] addr);
    bus_cycle(1'b1, 1'b0, 4'hf, addr, 32'h0);
  endtask

  function automatic logic [31:0] sram_addr(input logic [8:0] idx);
    return croc_lite_map_pkg::SramBaseAddr + {21'b0, idx, 2'b00};
  endfunction

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic check_reset_state();
    idle_cycle();
    check_pins();
    read_word(croc_lite_map_pkg::SocCtrlBaseAddr + 32'h0);
    read_word(croc_lite_map_pkg::SocCtrlBaseAddr + 32'h4);
    read_word(croc_lite_map_pkg::SocCtrlBaseAddr + 32'hc);
    read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h0);
    read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h4);
    read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h8);
    idle_cycle();
    end_test("reset_state");
  endtask

  task automatic sram_traffic();
    logic [31:0] addr;
    // Fill pattern spreads every address bit over the word
    for (int i = 0; i < int'(SramWords); i++) begin
      addr = sram_addr(9'(i));
      bus_cycle(1'b1, 1'b1, 4'hf, addr, addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1);
    end
    for (int i = 0; i < int'(SramOps); i++) begin
      addr = sram_addr(9'(rand_bits(9)));
      bus_cycle(1'b1, 1'(rand_bits(1)), 4'(rand_bits(4)), addr, rand_bits(32));
    end
    idle_cycle();
    end_test("sram_traffic");
  endtask

  task automatic soc_ctrl_traffic();
    logic        we;
    logic [31:0] addr;
    for (int i = 0; i < int'(SocOps); i++) begin
      fetch_en_nxt = 1'(rand_bits(1));
      we   = 1'(rand_bits(1));
      addr = croc_lite_map_pkg::SocCtrlBaseAddr + (rand_bits(1) == 32'h1 ? 32'h4 : 32'h0);
      bus_cycle(1'b1, we, 4'(rand_bits(4)), addr, rand_bits(32));
      idle_cycle();
      check_pins();
    end
    end_test("soc_ctrl_traffic");
  endtask

  task automatic gpio_loopback();
    for (int i = 0; i < int'(GpioRounds); i++) begin
      bus_cycle(1'b1, 1'b1, 4'(rand_bits(4)), croc_lite_map_pkg::GpioBaseAddr, rand_bits(32));
      bus_cycle(1'b1, 1'b1, 4'(rand_bits(4)), croc_lite_map_pkg::GpioBaseAddr + 32'h4,
                rand_bits(32));
      // Read-only input register must ignore this
      bus_cycle(1'b1, 1'b1, 4'hf, croc_lite_map_pkg::GpioBaseAddr + 32'h8, rand_bits(32));
      idle_cycle();
      check_pins();
      gpio_nxt = 16'(rand_bits(16));
      repeat (4) idle_cycle();
      mdl_gpio_in = gpio_nxt;
      read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h8);
      read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h0);
      read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h4);
    end
    idle_cycle();
    end_test("gpio_loopback");
  endtask

  task automatic unmapped_accesses();
    logic [31:0] addr;
    logic        we;
    for (int i = 0; i < int'(ErrOps); i++) begin
      addr = rand_bits(32);
      // Push mapped hits into the empty upper half
      if (target_of(addr) != croc_lite_bus_pkg::TgtError) begin
        addr[31] = 1'b1;
      end
      we = 1'(rand_bits(1));
      bus_cycle(1'b1, we, 4'(rand_bits(4)), addr, rand_bits(32));
    end
    idle_cycle();
    check_pins();
    read_word(croc_lite_map_pkg::SocCtrlBaseAddr + 32'h0);
    read_word(croc_lite_map_pkg::SocCtrlBaseAddr + 32'h4);
    read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h0);
    read_word(croc_lite_map_pkg::GpioBaseAddr + 32'h4);
    for (int i = 0; i < 4; i++) begin
      read_word(sram_addr(9'(rand_bits(9))));
    end
    idle_cycle();
    end_test("unmapped_accesses");
  endtask

  initial begin
    lfsr_q        = 32'hdb67_bac9;
    rst_n_i       = 1'b0;
    obi_req_i     = 1'b0;
    obi_we_i      = 1'b0;
    obi_be_i      = '0;
    obi_addr_i    = '0;
    obi_wdata_i   = '0;
    gpio_i        = '0;
    fetch_en_i    = 1'b0;
    fetch_en_nxt  = 1'b0;
    gpio_nxt      = '0;
    exp_valid     = 1'b0;
    exp_err       = 1'b0;
    exp_rdata     = '0;
    mdl_boot_addr = croc_lite_map_pkg::BootAddrDefault;
    mdl_fetch_en  = 1'b0;
    mdl_gpio_dir  = '0;
    mdl_gpio_out  = '0;
    mdl_gpio_in   = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    check_reset_state();
    sram_traffic();
    soc_ctrl_traffic();
    gpio_loopback();
    unmapped_accesses();

    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
src/croc_lite_bus_pkg.sv
src/croc_lite_map_pkg.sv
src/obi_bus_if.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/gpio_ctrl.sv
src/obi_addr_decode.sv
src/croc_lite_top.sv
sim/croc_lite_asserts.sv
sim/tb_croc_lite.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module tb_croc_lite -o tb_croc_lite > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_croc_lite > sim.log 2>&1 || echo "Checks failed" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0
